//--- hdl/core_pkg.sv
package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;

	// ########################################################################
	// major opcodes.
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;

	// ########################################################################
	// alu operations.
	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_SLL = 4'd2;
	localparam logic [3:0] ALU_SLT = 4'd3;
	localparam logic [3:0] ALU_SLTU = 4'd4;
	localparam logic [3:0] ALU_XOR = 4'd5;
	localparam logic [3:0] ALU_SRL = 4'd6;
	localparam logic [3:0] ALU_SRA = 4'd7;
	localparam logic [3:0] ALU_OR = 4'd8;
	localparam logic [3:0] ALU_AND = 4'd9;
	localparam logic [3:0] ALU_PASS_B = 4'd10; // lui.

	// branch kinds match funct3.
	localparam logic [2:0] BR_EQ = 3'b000;
	localparam logic [2:0] BR_NE = 3'b001;
	localparam logic [2:0] BR_LT = 3'b100;
	localparam logic [2:0] BR_GE = 3'b101;
	localparam logic [2:0] BR_LTU = 3'b110;
	localparam logic [2:0] BR_GEU = 3'b111;

	// operand source in execute.
	localparam logic FWD_REG = 1'b0;
	localparam logic FWD_WB = 1'b1;

	localparam logic [XLEN-1:0] RESET_PC = '0;
	localparam logic [31:0] NOP_INSN = 32'h0000_0013; // addi x0, x0, 0.

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            redirect_i,
	input  logic [XLEN-1:0] redirect_pc_i,
	input  logic            flush_i,
	output logic [XLEN-1:0] wb_adr_o,
	output logic            wb_cyc_o,
	output logic            wb_stb_o,
	output logic            wb_we_o,
	output logic [3:0]      wb_sel_o,
	input  logic [31:0]     wb_dat_i,
	input  logic            wb_ack_i,
	output logic            if_valid_o,
	output logic [XLEN-1:0] if_pc_o,
	output logic [31:0]     if_insn_o
);

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] adr_q;
	logic            cyc_q;
	logic            discard_q; // ack of a cycle started before a redirect.
	logic            buf_valid_q;
	logic [XLEN-1:0] buf_pc_q;
	logic [31:0]     buf_insn_q;
	logic            start;
	logic            ack_ok;

	assign start = !cyc_q && !buf_valid_q && !flush_i;
	assign ack_ok = cyc_q && wb_ack_i && !discard_q && !flush_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			pc_q <= RESET_PC;
			cyc_q <= 1'b0;
			discard_q <= 1'b0;
			buf_valid_q <= 1'b0;
		end
		else
		begin
			if (redirect_i)
				pc_q <= redirect_pc_i;
			else if (ack_ok)
				pc_q <= pc_q + XLEN'(4);

			if (cyc_q && wb_ack_i)
				cyc_q <= 1'b0; // idle for at least one cycle after ack.
			else if (start)
				cyc_q <= 1'b1;

			if (cyc_q && wb_ack_i)
				discard_q <= 1'b0;
			else if (cyc_q && flush_i)
				discard_q <= 1'b1;

			buf_valid_q <= ack_ok; // decode drains it every cycle.
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			adr_q <= {pc_q[XLEN-1:2], 2'b00};
		if (ack_ok)
		begin
			buf_pc_q <= adr_q;
			buf_insn_q <= wb_dat_i;
		end
	end

	assign wb_adr_o = adr_q;
	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = cyc_q;
	assign wb_we_o = 1'b0;
	assign wb_sel_o = 4'hf;

	assign if_valid_o = buf_valid_q;
	assign if_pc_o = buf_pc_q;
	assign if_insn_o = buf_valid_q ? buf_insn_q : NOP_INSN;

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import core_pkg::*; (
	input  logic [31:0]       insn_i,
	output logic [REG_AW-1:0] rs1_o,
	output logic [REG_AW-1:0] rs2_o,
	output logic [REG_AW-1:0] rd_o,
	output logic [XLEN-1:0]   imm_o,
	output logic [3:0]        alu_op_o,
	output logic              src_a_pc_o,
	output logic              src_b_imm_o,
	output logic              is_branch_o,
	output logic [2:0]        br_kind_o,
	output logic              jal_o,
	output logic              jalr_o,
	output logic              reg_write_o,
	output logic              lui_o
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            funct7_5;
	logic [XLEN-1:0] imm_i_t;
	logic [XLEN-1:0] imm_u_t;
	logic [XLEN-1:0] imm_b_t;
	logic [XLEN-1:0] imm_j_t;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];
	assign funct7_5 = insn_i[30];

	assign rs1_o = insn_i[19:15];
	assign rs2_o = insn_i[24:20];
	assign rd_o = insn_i[11:7];
	assign br_kind_o = funct3;

	assign imm_i_t = {{20{insn_i[31]}}, insn_i[31:20]};
	assign imm_u_t = {insn_i[31:12], 12'b0};
	assign imm_b_t = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
		insn_i[11:8], 1'b0};
	assign imm_j_t = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
		insn_i[30:21], 1'b0};

	always_comb
	begin
		imm_o = imm_i_t;
		alu_op_o = ALU_ADD;
		src_a_pc_o = 1'b0;
		src_b_imm_o = 1'b0;
		is_branch_o = 1'b0;
		jal_o = 1'b0;
		jalr_o = 1'b0;
		reg_write_o = 1'b0; // anything unknown is a nop.
		lui_o = 1'b0;
		case (opcode)
			OPC_OP, OPC_OP_IMM:
			begin
				reg_write_o = 1'b1;
				src_b_imm_o = (opcode == OPC_OP_IMM);
				case (funct3)
					3'b000: alu_op_o = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
					3'b001: alu_op_o = ALU_SLL;
					3'b010: alu_op_o = ALU_SLT;
					3'b011: alu_op_o = ALU_SLTU;
					3'b100: alu_op_o = ALU_XOR;
					3'b101: alu_op_o = funct7_5 ? ALU_SRA : ALU_SRL;
					3'b110: alu_op_o = ALU_OR;
					default: alu_op_o = ALU_AND;
				endcase
			end
			OPC_LUI:
			begin
				imm_o = imm_u_t;
				alu_op_o = ALU_PASS_B;
				src_b_imm_o = 1'b1;
				reg_write_o = 1'b1;
				lui_o = 1'b1;
			end
			OPC_AUIPC:
			begin
				imm_o = imm_u_t;
				src_a_pc_o = 1'b1;
				src_b_imm_o = 1'b1;
				reg_write_o = 1'b1;
			end
			OPC_BRANCH:
			begin
				imm_o = imm_b_t;
				is_branch_o = (funct3[2:1] != 2'b01); // 010 and 011 are reserved.
			end
			OPC_JAL:
			begin
				imm_o = imm_j_t;
				jal_o = 1'b1;
				reg_write_o = 1'b1;
			end
			OPC_JALR:
			begin
				jalr_o = 1'b1;
				reg_write_o = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic [REG_AW-1:0] ra1_i,
	input  logic [REG_AW-1:0] ra2_i,
	output logic [XLEN-1:0]   rd1_o,
	output logic [XLEN-1:0]   rd2_o,
	input  logic              we_i,
	input  logic [REG_AW-1:0] wa_i,
	input  logic [XLEN-1:0]   wd_i
);

	logic [XLEN-1:0] regs [2**REG_AW];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < 2**REG_AW; i++)
				regs[i] <= '0;
		end
		else if (we_i && wa_i != '0)
			regs[wa_i] <= wd_i;
	end

	// write-through lets the writeback value reach decode in the same cycle.
	assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
	assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

//--- hdl/id_ex_regs.sv
`timescale 1ns/1ps

module id_ex_regs import core_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              flush_i,
	input  logic              stall_i,
	input  logic [XLEN-1:0]   pc_i,
	input  logic [XLEN-1:0]   pc4_i,
	input  logic [XLEN-1:0]   imm_i,
	input  logic [XLEN-1:0]   rs1_data_i,
	input  logic [XLEN-1:0]   rs2_data_i,
	input  logic [REG_AW-1:0] rs1_i,
	input  logic [REG_AW-1:0] rs2_i,
	input  logic [REG_AW-1:0] rd_i,
	input  logic [3:0]        alu_op_i,
	input  logic              src_a_pc_i,
	input  logic              src_b_imm_i,
	input  logic              is_branch_i,
	input  logic [2:0]        br_kind_i,
	input  logic              jal_i,
	input  logic              jalr_i,
	input  logic              reg_write_i,
	input  logic              valid_i,
	output logic [XLEN-1:0]   pc_o,
	output logic [XLEN-1:0]   pc4_o,
	output logic [XLEN-1:0]   imm_o,
	output logic [XLEN-1:0]   rs1_data_o,
	output logic [XLEN-1:0]   rs2_data_o,
	output logic [REG_AW-1:0] rs1_o,
	output logic [REG_AW-1:0] rs2_o,
	output logic [REG_AW-1:0] rd_o,
	output logic [3:0]        alu_op_o,
	output logic              src_a_pc_o,
	output logic              src_b_imm_o,
	output logic              is_branch_o,
	output logic [2:0]        br_kind_o,
	output logic              jal_o,
	output logic              jalr_o,
	output logic              reg_write_o,
	output logic              valid_o
);

	always_ff @(posedge clk)
	begin
		if (rst_i || flush_i || stall_i)
		begin
			// bubble.
			pc_o <= '0;
			pc4_o <= '0;
			imm_o <= '0;
			rs1_data_o <= '0;
			rs2_data_o <= '0;
			rs1_o <= '0;
			rs2_o <= '0;
			rd_o <= '0;
			alu_op_o <= ALU_ADD;
			src_a_pc_o <= 1'b0;
			src_b_imm_o <= 1'b0;
			is_branch_o <= 1'b0;
			br_kind_o <= BR_EQ;
			jal_o <= 1'b0;
			jalr_o <= 1'b0;
			reg_write_o <= 1'b0;
			valid_o <= 1'b0;
		end
		else
		begin
			pc_o <= pc_i;
			pc4_o <= pc4_i;
			imm_o <= imm_i;
			rs1_data_o <= rs1_data_i;
			rs2_data_o <= rs2_data_i;
			rs1_o <= rs1_i;
			rs2_o <= rs2_i;
			rd_o <= rd_i;
			alu_op_o <= alu_op_i;
			src_a_pc_o <= src_a_pc_i;
			src_b_imm_o <= src_b_imm_i;
			is_branch_o <= is_branch_i;
			br_kind_o <= br_kind_i;
			jal_o <= jal_i;
			jalr_o <= jalr_i;
			reg_write_o <= reg_write_i;
			valid_o <= valid_i;
		end
	end

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic [XLEN-1:0]   pc_i,
	input  logic [XLEN-1:0]   pc4_i,
	input  logic [XLEN-1:0]   imm_i,
	input  logic [XLEN-1:0]   rs1_data_i,
	input  logic [XLEN-1:0]   rs2_data_i,
	input  logic [REG_AW-1:0] rd_i,
	input  logic [3:0]        alu_op_i,
	input  logic              src_a_pc_i,
	input  logic              src_b_imm_i,
	input  logic              is_branch_i,
	input  logic [2:0]        br_kind_i,
	input  logic              jal_i,
	input  logic              jalr_i,
	input  logic              reg_write_i,
	input  logic              valid_i,
	input  logic              fwd_a_i,
	input  logic              fwd_b_i,
	output logic              redirect_o,
	output logic [XLEN-1:0]   redirect_pc_o,
	output logic              wb_valid_o,
	output logic              wb_we_o,
	output logic [REG_AW-1:0] wb_rd_o,
	output logic [XLEN-1:0]   wb_data_o,
	output logic              retire_valid_o,
	output logic [XLEN-1:0]   retire_pc_o,
	output logic [REG_AW-1:0] retire_rd_o,
	output logic              retire_wen_o,
	output logic [XLEN-1:0]   retire_data_o
);

	logic [XLEN-1:0]   rs1_val;
	logic [XLEN-1:0]   rs2_val;
	logic [XLEN-1:0]   op_a;
	logic [XLEN-1:0]   op_b;
	logic [XLEN-1:0]   alu_res;
	logic [XLEN-1:0]   jalr_sum;
	logic              br_taken;
	logic              wb_valid_q;
	logic              wb_we_q;
	logic [REG_AW-1:0] wb_rd_q;
	logic [XLEN-1:0]   wb_data_q;
	logic [XLEN-1:0]   wb_pc_q;

	// ########################################################################
	// forwarding and alu.
	assign rs1_val = (fwd_a_i == FWD_WB) ? wb_data_q : rs1_data_i;
	assign rs2_val = (fwd_b_i == FWD_WB) ? wb_data_q : rs2_data_i;
	assign op_a = src_a_pc_i ? pc_i : rs1_val;
	assign op_b = src_b_imm_i ? imm_i : rs2_val;

	always_comb
	begin
		case (alu_op_i)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_SLL: alu_res = op_a << op_b[4:0];
			ALU_SLT: alu_res = XLEN'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_res = XLEN'(op_a < op_b);
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_SRL: alu_res = op_a >> op_b[4:0];
			ALU_SRA: alu_res = $signed(op_a) >>> op_b[4:0];
			ALU_OR: alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			default: alu_res = op_b; // pass b.
		endcase
	end

	// ########################################################################
	// branch and jump resolution.
	always_comb
	begin
		case (br_kind_i)
			BR_EQ: br_taken = (rs1_val == rs2_val);
			BR_NE: br_taken = (rs1_val != rs2_val);
			BR_LT: br_taken = ($signed(rs1_val) < $signed(rs2_val));
			BR_GE: br_taken = ($signed(rs1_val) >= $signed(rs2_val));
			BR_LTU: br_taken = (rs1_val < rs2_val);
			BR_GEU: br_taken = (rs1_val >= rs2_val);
			default: br_taken = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_val + imm_i;
	assign redirect_o = valid_i && (jal_i || jalr_i || (is_branch_i && br_taken));
	assign redirect_pc_o = jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

	// ex/wb register.
	always_ff @(posedge clk)
	begin
		if (rst_i)
			wb_valid_q <= 1'b0;
		else
			wb_valid_q <= valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (valid_i)
		begin
			wb_we_q <= reg_write_i;
			wb_rd_q <= rd_i;
			wb_data_q <= (jal_i || jalr_i) ? pc4_i : alu_res; // link value.
			wb_pc_q <= pc_i;
		end
	end

	assign wb_valid_o = wb_valid_q;
	assign wb_we_o = wb_we_q;
	assign wb_rd_o = wb_rd_q;
	assign wb_data_o = wb_data_q;

	assign retire_valid_o = wb_valid_q;
	assign retire_pc_o = wb_pc_q;
	assign retire_rd_o = wb_rd_q;
	assign retire_wen_o = wb_we_q;
	assign retire_data_o = wb_data_q;

endmodule

//--- hdl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl import core_pkg::*; (
	input  logic              if_valid_i,
	input  logic              redirect_i,
	input  logic [REG_AW-1:0] ex_rs1_i,
	input  logic [REG_AW-1:0] ex_rs2_i,
	input  logic              wb_we_i,
	input  logic [REG_AW-1:0] wb_rd_i,
	output logic              id_bubble_o,
	output logic              flush_o,
	output logic              fwd_a_o,
	output logic              fwd_b_o
);

	logic wb_live;

	// nothing fetched, so decode hands a bubble to execute.
	assign id_bubble_o = !if_valid_i;

	// taken redirect kills decode and the fetch buffer together.
	assign flush_o = redirect_i;

	assign wb_live = wb_we_i && (wb_rd_i != '0);

	always_comb
	begin
		fwd_a_o = FWD_REG;
		fwd_b_o = FWD_REG;
		if (wb_live && wb_rd_i == ex_rs1_i)
			fwd_a_o = FWD_WB;
		if (wb_live && wb_rd_i == ex_rs2_i)
			fwd_b_o = FWD_WB;
	end

endmodule

//--- hdl/pipe_core.sv
`timescale 1ns/1ps

module pipe_core import core_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	output logic [XLEN-1:0]   wb_adr_o,
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output logic              wb_we_o,
	output logic [3:0]        wb_sel_o,
	input  logic [31:0]       wb_dat_i,
	input  logic              wb_ack_i,
	output logic              retire_valid_o,
	output logic [XLEN-1:0]   retire_pc_o,
	output logic [REG_AW-1:0] retire_rd_o,
	output logic              retire_wen_o,
	output logic [XLEN-1:0]   retire_data_o
);

	logic              if_valid;
	logic [XLEN-1:0]   if_pc;
	logic [31:0]       if_insn;
	logic [REG_AW-1:0] dec_rs1, dec_rs2, dec_rd, id_rs1;
	logic [XLEN-1:0]   dec_imm;
	logic [3:0]        dec_alu_op;
	logic              dec_src_a_pc, dec_src_b_imm, dec_is_branch;
	logic [2:0]        dec_br_kind;
	logic              dec_jal, dec_jalr, dec_reg_write, dec_lui;
	logic [XLEN-1:0]   rf_rd1, rf_rd2;
	logic [XLEN-1:0]   ex_pc, ex_pc4, ex_imm, ex_rs1_data, ex_rs2_data;
	logic [REG_AW-1:0] ex_rs1, ex_rs2, ex_rd;
	logic [3:0]        ex_alu_op;
	logic              ex_src_a_pc, ex_src_b_imm, ex_is_branch;
	logic [2:0]        ex_br_kind;
	logic              ex_jal, ex_jalr, ex_reg_write, ex_valid;
	logic              redirect, flush, id_bubble, fwd_a, fwd_b;
	logic [XLEN-1:0]   redirect_pc;
	logic              exwb_valid, exwb_we, rf_we;
	logic [REG_AW-1:0] exwb_rd;
	logic [XLEN-1:0]   exwb_data;

	// zero the rs1 index of lui so its immediate bits never look like a source.
	assign id_rs1 = dec_lui ? '0 : dec_rs1;
	assign rf_we = exwb_valid && exwb_we;

	fetch_unit u_fetch (.clk, .rst_i, .redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.flush_i(flush), .wb_adr_o, .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_sel_o, .wb_dat_i,
		.wb_ack_i, .if_valid_o(if_valid), .if_pc_o(if_pc), .if_insn_o(if_insn));

	inst_decoder u_dec (.insn_i(if_insn), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
		.imm_o(dec_imm), .alu_op_o(dec_alu_op), .src_a_pc_o(dec_src_a_pc),
		.src_b_imm_o(dec_src_b_imm), .is_branch_o(dec_is_branch), .br_kind_o(dec_br_kind),
		.jal_o(dec_jal), .jalr_o(dec_jalr), .reg_write_o(dec_reg_write), .lui_o(dec_lui));

	reg_file u_rf (.clk, .rst_i, .ra1_i(id_rs1), .ra2_i(dec_rs2), .rd1_o(rf_rd1),
		.rd2_o(rf_rd2), .we_i(rf_we), .wa_i(exwb_rd), .wd_i(exwb_data));

	id_ex_regs u_id_ex (.clk, .rst_i, .flush_i(flush), .stall_i(id_bubble),
		.pc_i(if_pc), .pc4_i(if_pc + XLEN'(4)), .imm_i(dec_imm), .rs1_data_i(rf_rd1),
		.rs2_data_i(rf_rd2), .rs1_i(id_rs1), .rs2_i(dec_rs2), .rd_i(dec_rd),
		.alu_op_i(dec_alu_op), .src_a_pc_i(dec_src_a_pc), .src_b_imm_i(dec_src_b_imm),
		.is_branch_i(dec_is_branch), .br_kind_i(dec_br_kind), .jal_i(dec_jal),
		.jalr_i(dec_jalr), .reg_write_i(dec_reg_write), .valid_i(if_valid),
		.pc_o(ex_pc), .pc4_o(ex_pc4), .imm_o(ex_imm), .rs1_data_o(ex_rs1_data),
		.rs2_data_o(ex_rs2_data), .rs1_o(ex_rs1), .rs2_o(ex_rs2), .rd_o(ex_rd),
		.alu_op_o(ex_alu_op), .src_a_pc_o(ex_src_a_pc), .src_b_imm_o(ex_src_b_imm),
		.is_branch_o(ex_is_branch), .br_kind_o(ex_br_kind), .jal_o(ex_jal),
		.jalr_o(ex_jalr), .reg_write_o(ex_reg_write), .valid_o(ex_valid));

	exec_unit u_ex (.clk, .rst_i, .pc_i(ex_pc), .pc4_i(ex_pc4), .imm_i(ex_imm),
		.rs1_data_i(ex_rs1_data), .rs2_data_i(ex_rs2_data), .rd_i(ex_rd),
		.alu_op_i(ex_alu_op), .src_a_pc_i(ex_src_a_pc), .src_b_imm_i(ex_src_b_imm),
		.is_branch_i(ex_is_branch), .br_kind_i(ex_br_kind), .jal_i(ex_jal),
		.jalr_i(ex_jalr), .reg_write_i(ex_reg_write), .valid_i(ex_valid),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .redirect_o(redirect),
		.redirect_pc_o(redirect_pc), .wb_valid_o(exwb_valid), .wb_we_o(exwb_we),
		.wb_rd_o(exwb_rd), .wb_data_o(exwb_data), .retire_valid_o, .retire_pc_o,
		.retire_rd_o, .retire_wen_o, .retire_data_o);

	hazard_ctrl u_hz (.if_valid_i(if_valid), .redirect_i(redirect), .ex_rs1_i(ex_rs1),
		.ex_rs2_i(ex_rs2), .wb_we_i(rf_we), .wb_rd_i(exwb_rd), .id_bubble_o(id_bubble),
		.flush_o(flush), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b));

endmodule

//--- verification/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// one retired instruction as the ISA sees it.
typedef struct packed {
	logic [31:0] pc;
	logic        wen;
	logic [4:0]  rd;
	logic [31:0] data;
} retire_rec_t;

logic [31:0] arch_regs [32];
logic [31:0] arch_pc;

function automatic void clear_arch_state();
	for (int i = 0; i < 32; i++)
		arch_regs[i] = '0;
	arch_pc = RESET_PC;
endfunction

// alt selects sub or sra.
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic signed [31:0] sa;
	logic [31:0]        res;
	sa = a;
	case (f3)
		3'b000: res = alt ? a - b : a + b;
		3'b001: res = a << b[4:0];
		3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b011: res = (a < b) ? 32'd1 : 32'd0;
		3'b100: res = a ^ b;
		3'b101:
		begin
			if (alt)
				res = sa >>> b[4:0];
			else
				res = a >> b[4:0];
		end
		3'b110: res = a | b;
		default: res = a & b;
	endcase
	return res;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	logic taken;
	case (f3)
		3'b000: taken = (a == b);
		3'b001: taken = (a != b);
		3'b100: taken = ($signed(a) < $signed(b));
		3'b101: taken = ($signed(a) >= $signed(b));
		3'b110: taken = (a < b);
		default: taken = (a >= b);
	endcase
	return taken;
endfunction

// runs one instruction and returns what the core should retire for it.
function automatic retire_rec_t exec_insn(input logic [31:0] insn);
	retire_rec_t rec;
	logic [2:0]  f3;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] next_pc;
	f3 = insn[14:12];
	a = arch_regs[insn[19:15]];
	b = arch_regs[insn[24:20]];
	imm_i = {{20{insn[31]}}, insn[31:20]};
	imm_u = {insn[31:12], 12'h000};
	imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	rec.pc = arch_pc;
	rec.rd = insn[11:7];
	rec.wen = 1'b1;
	rec.data = '0;
	next_pc = arch_pc + 32'd4;
	case (insn[6:0])
		OPC_OP: rec.data = alu_result(f3, insn[30], a, b);
		OPC_OP_IMM: rec.data = alu_result(f3, (f3 == 3'b101) && insn[30], a, imm_i);
		OPC_LUI: rec.data = imm_u;
		OPC_AUIPC: rec.data = arch_pc + imm_u;
		OPC_JAL:
		begin
			rec.data = arch_pc + 32'd4;
			next_pc = arch_pc + imm_j;
		end
		OPC_JALR:
		begin
			rec.data = arch_pc + 32'd4;
			next_pc = (a + imm_i) & ~32'd1;
		end
		OPC_BRANCH:
		begin
			rec.wen = 1'b0;
			if (branch_taken(f3, a, b))
				next_pc = arch_pc + imm_b;
		end
		default: rec.wen = 1'b0;
	endcase
	if (rec.wen && rec.rd != '0)
		arch_regs[rec.rd] = rec.data; // x0 never changes.
	arch_pc = next_pc;
	return rec;
endfunction

`endif

//--- verification/tb_pipe_core.sv
`timescale 1ns/1ps

module tb_pipe_core import core_pkg::*; ();

	localparam int NUM_RETIRES = 300;
	localparam int CYCLE_LIMIT = NUM_RETIRES * 12 + 50;
	localparam int PROG_WORDS = 64;

	// slot kinds of the generated program.
	localparam int K_ALU = 0;
	localparam int K_BRANCH = 1;
	localparam int K_JAL = 2;
	localparam int K_LUI = 3;
	localparam int K_AUIPC = 4;
	localparam int K_PAIR_LUI = 5;
	localparam int K_PAIR_ADDI = 6;
	localparam int K_JALR = 7;
	localparam int K_FINAL = 8;

	logic              clk;
	logic              rst_i;
	logic [XLEN-1:0]   wb_adr_o;
	logic              wb_cyc_o;
	logic              wb_stb_o;
	logic              wb_we_o;
	logic [3:0]        wb_sel_o;
	logic [31:0]       wb_dat_i;
	logic              wb_ack_i;
	logic              retire_valid_o;
	logic [XLEN-1:0]   retire_pc_o;
	logic [REG_AW-1:0] retire_rd_o;
	logic              retire_wen_o;
	logic [XLEN-1:0]   retire_data_o;

	integer      seed;
	logic [31:0] prog_mem [PROG_WORDS];
	int          slot_kind [PROG_WORDS];
	logic [2:0]  branch_funct3 [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
	int          retire_count;
	int          cycle_count;
	int          wait_left;
	logic        req_open;
	logic        reset_seen;
	logic        prev_cyc;
	logic        prev_ack;
	logic [31:0] prev_adr;

	`include "ref_model.svh"

	pipe_core DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [4:0] dest_reg();
		return (random_below(8) == 0) ? 5'd0 : 5'(1 + random_below(30)); // x31 is the jalr base.
	endfunction

	// half the sources reuse the last destination.
	function automatic logic [4:0] source_reg(input logic [4:0] last_rd);
		return (random_below(2) == 0) ? last_rd : 5'(random_below(32));
	endfunction

	// skip the middle of a lui/addi/jalr group.
	function automatic int landing_slot(input int want);
		int j;
		j = (want > PROG_WORDS - 1) ? PROG_WORDS - 1 : want;
		while (slot_kind[j] == K_PAIR_ADDI || slot_kind[j] == K_JALR)
			j++;
		return j;
	endfunction

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd,
		input logic [6:0] opc);
		return {off[20], off[10:1], off[11], off[19:12], rd, opc};
	endfunction

	// ########################################################################
	// program generation.
	task automatic build_program();
		int          i;
		int          pick;
		int          tgt;
		int          pair_tgt;
		logic [4:0]  last_rd;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		i = 0;
		last_rd = '0;
		pair_tgt = 0;
		while (i < PROG_WORDS - 1)
		begin
			pick = random_below(16);
			if (pick == 0 && i + 3 < PROG_WORDS - 1)
			begin
				slot_kind[i] = K_PAIR_LUI;
				slot_kind[i + 1] = K_PAIR_ADDI;
				slot_kind[i + 2] = K_JALR;
				i = i + 3;
			end
			else
			begin
				case (pick)
					10, 11: slot_kind[i] = K_BRANCH;
					12: slot_kind[i] = K_JAL;
					13: slot_kind[i] = K_LUI;
					14: slot_kind[i] = K_AUIPC;
					default: slot_kind[i] = K_ALU;
				endcase
				i = i + 1;
			end
		end
		slot_kind[PROG_WORDS - 1] = K_FINAL;

		for (int s = 0; s < PROG_WORDS; s++)
		begin
			rd = dest_reg();
			rs1 = source_reg(last_rd);
			rs2 = source_reg(last_rd);
			f3 = 3'(random_below(8));
			case (slot_kind[s])
				K_ALU:
				begin
					f7 = ((f3 == 3'b000 || f3 == 3'b101) && random_below(2) == 1) ? 7'h20 : 7'h00;
					if (random_below(2) == 0)
						prog_mem[s] = r_format(f7, rs2, rs1, f3, rd, OPC_OP);
					else
					begin
						imm = 12'($random(seed));
						if (f3 == 3'b001 || f3 == 3'b101)
							imm = {(f3 == 3'b101) ? f7 : 7'h00, 5'(random_below(32))};
						prog_mem[s] = i_format(imm, rs1, f3, rd, OPC_OP_IMM);
					end
					last_rd = rd;
				end
				K_BRANCH:
				begin
					tgt = landing_slot(s + 2 + random_below(3));
					prog_mem[s] = b_format(13'((tgt - s) * 4), rs2, rs1,
						branch_funct3[random_below(6)], OPC_BRANCH);
				end
				K_JAL:
				begin
					tgt = landing_slot(s + 2 + random_below(3));
					prog_mem[s] = j_format(21'((tgt - s) * 4), rd, OPC_JAL);
					last_rd = rd;
				end
				K_LUI, K_AUIPC:
				begin
					prog_mem[s] = u_format(20'($random(seed)), rd,
						(slot_kind[s] == K_LUI) ? OPC_LUI : OPC_AUIPC);
					last_rd = rd;
				end
				K_PAIR_LUI:
				begin
					pair_tgt = landing_slot(s + 3 + random_below(3));
					prog_mem[s] = u_format(20'h00000, 5'd31, OPC_LUI);
					last_rd = 5'd31;
				end
				K_PAIR_ADDI: prog_mem[s] = i_format(12'(pair_tgt * 4), 5'd31, 3'b000, 5'd31,
					OPC_OP_IMM);
				K_JALR:
				begin
					// an odd offset checks that bit 0 of the target is dropped.
					prog_mem[s] = i_format(12'(random_below(2)), 5'd31, 3'b000, rd, OPC_JALR);
					last_rd = rd;
				end
				default: prog_mem[s] = j_format('0, 5'd0, OPC_JAL); // spins here.
			endcase
		end
	endtask

	function automatic logic [31:0] fetch_word(input logic [31:0] adr);
		return (adr[31:8] == '0) ? prog_mem[adr[7:2]] : NOP_INSN;
	endfunction

	// ########################################################################
	// wishbone slave with 0 to 3 wait cycles per request.
	always @(posedge clk)
	begin
		if (rst_i)
		begin
			wb_ack_i <= 1'b0;
			req_open = 1'b0;
		end
		else if (wb_ack_i)
			wb_ack_i <= 1'b0;
		else if (wb_cyc_o && wb_stb_o)
		begin
			if (!req_open)
			begin
				wait_left = random_below(4);
				req_open = 1'b1;
			end
			if (wait_left == 0)
			begin
				wb_ack_i <= 1'b1;
				wb_dat_i <= fetch_word(wb_adr_o);
				req_open = 1'b0;
			end
			else
				wait_left--;
		end
	end

	task automatic check_bus();
		assert (!wb_we_o && wb_sel_o == 4'hf)
			else report_failure("fetch bus cycle is not a full-word read");
		assert (wb_stb_o == wb_cyc_o)
			else report_failure($sformatf("mismatch wb_stb_o: got %h expected %h",
				wb_stb_o, wb_cyc_o));
		if (wb_cyc_o)
			assert (wb_adr_o[1:0] == 2'b00)
				else report_failure($sformatf("mismatch wb_adr_o[1:0]: got %h expected 0",
					wb_adr_o[1:0]));
		if (prev_cyc && prev_ack)
			assert (!wb_cyc_o) else report_failure("bus not idle in the cycle after ack");
		else if (prev_cyc)
		begin
			assert (wb_cyc_o) else report_failure("bus cycle dropped before ack");
			assert (wb_adr_o == prev_adr)
				else report_failure($sformatf("mismatch wb_adr_o: got %h expected %h",
					wb_adr_o, prev_adr));
		end
	endtask

	task automatic check_retire();
		retire_rec_t exp;
		exp = exec_insn(prog_mem[arch_pc[7:2]]);
		assert (retire_pc_o == exp.pc)
			else report_failure($sformatf("mismatch retire_pc_o: got %h expected %h",
				retire_pc_o, exp.pc));
		assert (retire_wen_o == exp.wen)
			else report_failure($sformatf("mismatch retire_wen_o: got %h expected %h",
				retire_wen_o, exp.wen));
		if (exp.wen)
		begin
			assert (retire_rd_o == exp.rd)
				else report_failure($sformatf("mismatch retire_rd_o: got %h expected %h",
					retire_rd_o, exp.rd));
			if (exp.rd != '0)
				assert (retire_data_o == exp.data)
					else report_failure($sformatf("mismatch retire_data_o: got %h expected %h",
						retire_data_o, exp.data));
		end
		retire_count++;
	endtask

	// ########################################################################
	// monitor samples the values held before each edge.
	always @(posedge clk)
	begin
		cycle_count++;
		if (rst_i)
		begin
			if (reset_seen)
				assert (!wb_cyc_o && !wb_stb_o) else report_failure("bus cycle active in reset");
			reset_seen = 1'b1;
		end
		else if (reset_seen)
		begin
			check_bus();
			if (retire_valid_o)
				check_retire();
		end
		prev_cyc = wb_cyc_o;
		prev_ack = wb_ack_i;
		prev_adr = wb_adr_o;
	end

	initial
	begin
		seed = 32'h7b85;
		rst_i = 1'b1;
		wb_ack_i = 1'b0;
		wb_dat_i = '0;
		retire_count = 0;
		cycle_count = 0;
		wait_left = 0;
		req_open = 1'b0;
		reset_seen = 1'b0;
		prev_cyc = 1'b0;
		prev_ack = 1'b0;
		prev_adr = '0;
		clear_arch_state();
		build_program();
		repeat (4) @(posedge clk);
		rst_i <= 1'b0;
		while (retire_count < NUM_RETIRES && cycle_count < CYCLE_LIMIT)
			@(negedge clk);
		if (retire_count >= NUM_RETIRES)
		begin
			$display("All checks passed");
			$finish;
		end
		else
			report_failure("timeout, the core stopped retiring instructions");
	end

endmodule

//--- src.f
+incdir+verification
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/id_ex_regs.sv
hdl/exec_unit.sv
hdl/hazard_ctrl.sv
hdl/pipe_core.sv
verification/tb_pipe_core.sv
